// ==== hdl/stb_alloc.sv ====
`timescale 1ns/1ps
`default_nettype none

// Allocation side of the store buffer
// Owns the push and commit pointers plus the two counters, and turns the
// push and commit strobes into one-hot strobes for the slots

module stb_alloc (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          push_i,
    input  wire logic                          commit_i,
    input  wire logic                          flush_i,
    input  wire logic                          free_i,
    output logic [stb_pkg::STB_DEPTH-1:0]      entry_wr_o,
    output logic [stb_pkg::STB_DEPTH-1:0]      entry_commit_o,
    output logic [stb_pkg::STB_IDX_W-1:0]      push_idx_o,
    output logic                               full_o,
    output logic                               empty_o
);

    import stb_pkg::*;

    logic [STB_IDX_W-1:0] push_ptr_q;
    logic [STB_IDX_W-1:0] commit_ptr_q;

    // Counters need one extra bit to reach STB_DEPTH
    logic [STB_IDX_W:0]   occ_q, occ_d;
    logic [STB_IDX_W:0]   cmt_q, cmt_d;

    logic                 push_eff;
    logic                 commit_eff;
    logic                 full_q, empty_q;

    // Flush wins over a push or a commit arriving in the same cycle
    assign push_eff   = push_i && !flush_i;
    assign commit_eff = commit_i && !flush_i;

    // ======================================================================
    // Next counter values
    // ======================================================================

    always_comb begin : next_count
        // Committed stores survive a flush, so this count never rolls back
        cmt_d = cmt_q + (STB_IDX_W+1)'(commit_eff) - (STB_IDX_W+1)'(free_i);

        if (flush_i) begin
            // Only the committed stores remain after a flush
            occ_d = cmt_d;
        end else begin
            occ_d = occ_q + (STB_IDX_W+1)'(push_eff) - (STB_IDX_W+1)'(free_i);
        end
    end : next_count

    // ======================================================================
    // Pointers, counters and flags
    // ======================================================================

    always_ff @(posedge clk_i) begin : alloc_regs
        if (!rst_n_i) begin
            push_ptr_q   <= '0;
            commit_ptr_q <= '0;
            occ_q        <= '0;
            cmt_q        <= '0;
            full_q       <= 1'b0;
            empty_q      <= 1'b1;
        end else begin
            if (flush_i) begin
                // The youngest surviving store sits just below the commit pointer
                push_ptr_q <= commit_ptr_q;
            end else if (push_eff) begin
                push_ptr_q <= push_ptr_q + 1'b1;
            end

            if (commit_eff) begin
                commit_ptr_q <= commit_ptr_q + 1'b1;
            end

            occ_q   <= occ_d;
            cmt_q   <= cmt_d;
            full_q  <= (occ_d == (STB_IDX_W+1)'(STB_DEPTH));
            empty_q <= (occ_d == '0);
        end
    end : alloc_regs

    // One-hot strobes towards the slots
    always_comb begin : strobe_decode
        entry_wr_o                   = '0;
        entry_commit_o               = '0;
        entry_wr_o[push_ptr_q]       = push_eff;
        entry_commit_o[commit_ptr_q] = commit_eff;
    end : strobe_decode

    assign push_idx_o = push_ptr_q;
    assign full_o     = full_q;
    assign empty_o    = empty_q;

endmodule : stb_alloc

`default_nettype wire

// ==== hdl/stb_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

// Drain side of the store buffer
// Sends the oldest committed store to memory, one request at a time, and
// releases its slot when the memory controller reports completion

module stb_drain (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   mem_done_i,
    input  stb_pkg::entry_state_t       entry_state_i [stb_pkg::STB_DEPTH-1:0],
    input  stb_pkg::store_req_t         entry_data_i  [stb_pkg::STB_DEPTH-1:0],
    output logic                        mem_req_o,
    output stb_pkg::mem_write_t         mem_write_o,
    output logic [stb_pkg::STB_DEPTH-1:0] entry_free_o,
    output logic                        free_o
);

    import stb_pkg::*;

    logic [STB_IDX_W-1:0] pull_ptr_q;
    logic                 outstanding_q;
    logic                 done_eff;
    store_req_t           head;

    // Oldest slot in the buffer
    assign head = entry_data_i[pull_ptr_q];

    // A done without an open request is ignored
    assign done_eff = mem_done_i && outstanding_q;

    // ======================================================================
    // Request generation
    // ======================================================================

    // Single cycle strobe, the outstanding flag blocks it afterwards
    assign mem_req_o = (entry_state_i[pull_ptr_q] == ENTRY_COMMITTED) && !outstanding_q;

    // Pull pointer only moves on done, so the write stays stable meanwhile
    assign mem_write_o = '{addr: head.addr, width: head.width, data: head.data};

    always_ff @(posedge clk_i) begin : drain_regs
        if (!rst_n_i) begin
            pull_ptr_q    <= '0;
            outstanding_q <= 1'b0;
        end else begin
            if (done_eff) begin
                outstanding_q <= 1'b0;
                pull_ptr_q    <= pull_ptr_q + 1'b1;
            end else if (mem_req_o) begin
                outstanding_q <= 1'b1;
            end
        end
    end : drain_regs

    // ======================================================================
    // Slot release
    // ======================================================================

    always_comb begin : free_decode
        entry_free_o             = '0;
        entry_free_o[pull_ptr_q] = done_eff;
    end : free_decode

    // Tells the allocator that one committed store has left
    assign free_o = done_eff;

endmodule : stb_drain

`default_nettype wire

// ==== hdl/stb_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

// One slot of the store buffer
// The slot keeps its own life state, holds the store payload and checks
// itself against the address of the load that is probing the buffer

module stb_entry (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 wr_i,
    input  wire logic                 commit_i,
    input  wire logic                 free_i,
    input  wire logic                 flush_i,
    input  stb_pkg::store_req_t       wr_data_i,
    input  stb_pkg::data_word_t       fwd_addr_i,
    input  stb_pkg::store_width_t     fwd_width_i,
    output stb_pkg::entry_state_t     state_o,
    output stb_pkg::store_req_t       data_o,
    output logic                      overlap_o,
    output logic                      exact_o
);

    import stb_pkg::*;

    entry_state_t state_q;
    store_req_t   payload_q;
    logic         live;

    // ======================================================================
    // State tracking
    // ======================================================================

    // The drain unit only frees a committed slot and the allocator only
    // writes a free one, so the cases below never collide on one slot
    always_ff @(posedge clk_i) begin : state_reg
        if (!rst_n_i) begin
            state_q <= ENTRY_FREE;
        end else if (free_i) begin
            state_q <= ENTRY_FREE;
        end else if (flush_i && (state_q == ENTRY_PUSHED)) begin
            // A store that never retired is speculative and goes away
            state_q <= ENTRY_FREE;
        end else if (wr_i) begin
            state_q <= ENTRY_PUSHED;
        end else if (commit_i && (state_q == ENTRY_PUSHED)) begin
            state_q <= ENTRY_COMMITTED;
        end
    end : state_reg

    // Payload is captured on the write strobe and then left alone
    always_ff @(posedge clk_i) begin : payload_reg
        if (wr_i) begin
            payload_q <= wr_data_i;
        end
    end : payload_reg

    // ======================================================================
    // Load comparison
    // ======================================================================

    assign live = (state_q != ENTRY_FREE);

    // Same 32-bit word, whatever the bytes touched
    assign overlap_o = live && (payload_q.addr[31:2] == fwd_addr_i[31:2]);

    // Exact match also needs the same byte offset and the same size
    assign exact_o   = overlap_o && (payload_q.addr[1:0] == fwd_addr_i[1:0])
                       && (payload_q.width == fwd_width_i);

    assign state_o = state_q;
    assign data_o  = payload_q;

endmodule : stb_entry

`default_nettype wire

// ==== hdl/stb_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

// Store-to-load forwarding selector
// Walks the slots from youngest to oldest and lets the first one that
// touches the load's word decide between forwarding and waiting

module stb_forward (
    input  wire logic [stb_pkg::STB_IDX_W-1:0] push_idx_i,
    input  wire logic [stb_pkg::STB_DEPTH-1:0] overlap_i,
    input  wire logic [stb_pkg::STB_DEPTH-1:0] exact_i,
    input  stb_pkg::store_req_t                entry_data_i [stb_pkg::STB_DEPTH-1:0],
    output logic                               fwd_hit_o,
    output logic                               fwd_wait_o,
    output stb_pkg::data_word_t                fwd_data_o
);

    import stb_pkg::*;

    logic                 found;
    logic [STB_IDX_W-1:0] sel_idx;

    // ======================================================================
    // Age ordered search
    // ======================================================================

    // The slot just below the push pointer is the youngest one; stepping
    // further back wraps around to older stores
    always_comb begin : age_search
        logic [STB_IDX_W-1:0] idx;

        found   = 1'b0;
        sel_idx = '0;
        idx     = '0;
        for (int k = 1; k <= STB_DEPTH; k++) begin
            idx = push_idx_i - STB_IDX_W'(k);
            if (!found && overlap_i[idx]) begin
                found   = 1'b1;
                sel_idx = idx;
            end
        end
    end : age_search

    // Youngest overlapping store alone decides; an older exact match behind
    // a partial one would return stale bytes
    assign fwd_hit_o  = found && exact_i[sel_idx];
    assign fwd_wait_o = found && !exact_i[sel_idx];

    // Stored word comes back as is, without lane shifting
    assign fwd_data_o = entry_data_i[sel_idx].data;

endmodule : stb_forward

`default_nettype wire

// ==== hdl/stb_pkg.sv ====
`default_nettype none

// ==========================================================================
// Shared types and sizes of the store buffer
// ==========================================================================

package stb_pkg;

    // Number of store slots, must stay a power of two so the pointers wrap
    localparam int STB_DEPTH = 4;
    localparam int STB_IDX_W = 2;

    // Address and data both travel as one 32-bit word
    typedef logic [31:0] data_word_t;

    // Access size of a store or of a load probing the buffer
    typedef enum logic [1:0] {
        STORE_BYTE = 2'b00,
        STORE_HALF = 2'b01,
        STORE_WORD = 2'b10
    } store_width_t;

    // Store as pushed by the store unit and as held in a slot
    typedef struct packed {
        data_word_t   addr;
        store_width_t width;
        data_word_t   data;
    } store_req_t;

    // Write presented to the memory controller
    typedef struct packed {
        data_word_t   addr;
        store_width_t width;
        data_word_t   data;
    } mem_write_t;

    // Life cycle of a single slot
    typedef enum logic [1:0] {
        ENTRY_FREE      = 2'b00,
        ENTRY_PUSHED    = 2'b01,
        ENTRY_COMMITTED = 2'b10
    } entry_state_t;

endpackage : stb_pkg

`default_nettype wire

// ==== hdl/store_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Store buffer of the load/store unit
// Stores enter from the store unit, get committed by the reorder buffer,
// drain to memory in order and can feed younger loads on the way

module store_buffer_top (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            push_i,
    input  stb_pkg::store_req_t  push_req_i,
    input  wire logic            commit_i,
    input  wire logic            flush_i,
    input  stb_pkg::data_word_t  fwd_addr_i,
    input  stb_pkg::store_width_t fwd_width_i,
    output logic                 fwd_hit_o,
    output logic                 fwd_wait_o,
    output stb_pkg::data_word_t  fwd_data_o,
    output logic                 mem_req_o,
    output stb_pkg::mem_write_t  mem_write_o,
    input  wire logic            mem_done_i,
    output logic                 full_o,
    output logic                 empty_o
);

    import stb_pkg::*;

    logic [STB_DEPTH-1:0] entry_wr;
    logic [STB_DEPTH-1:0] entry_commit;
    logic [STB_DEPTH-1:0] entry_free;
    logic [STB_DEPTH-1:0] entry_overlap;
    logic [STB_DEPTH-1:0] entry_exact;
    logic [STB_IDX_W-1:0] push_idx;
    logic                 free;
    entry_state_t         entry_state [STB_DEPTH-1:0];
    store_req_t           entry_data  [STB_DEPTH-1:0];

    // ======================================================================
    // Allocation
    // ======================================================================

    stb_alloc u_alloc (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .push_i         (push_i),
        .commit_i       (commit_i),
        .flush_i        (flush_i),
        .free_i         (free),
        .entry_wr_o     (entry_wr),
        .entry_commit_o (entry_commit),
        .push_idx_o     (push_idx),
        .full_o         (full_o),
        .empty_o        (empty_o)
    );

    // ======================================================================
    // Slots
    // ======================================================================

    // Every slot sees the same push payload and load probe
    for (genvar i = 0; i < STB_DEPTH; i++) begin : g_entry
        stb_entry u_entry (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .wr_i        (entry_wr[i]),
            .commit_i    (entry_commit[i]),
            .free_i      (entry_free[i]),
            .flush_i     (flush_i),
            .wr_data_i   (push_req_i),
            .fwd_addr_i  (fwd_addr_i),
            .fwd_width_i (fwd_width_i),
            .state_o     (entry_state[i]),
            .data_o      (entry_data[i]),
            .overlap_o   (entry_overlap[i]),
            .exact_o     (entry_exact[i])
        );
    end : g_entry

    // Forwarding to loads
    stb_forward u_forward (
        .push_idx_i   (push_idx),
        .overlap_i    (entry_overlap),
        .exact_i      (entry_exact),
        .entry_data_i (entry_data),
        .fwd_hit_o    (fwd_hit_o),
        .fwd_wait_o   (fwd_wait_o),
        .fwd_data_o   (fwd_data_o)
    );

    // Drain towards the memory controller
    stb_drain u_drain (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .mem_done_i    (mem_done_i),
        .entry_state_i (entry_state),
        .entry_data_i  (entry_data),
        .mem_req_o     (mem_req_o),
        .mem_write_o   (mem_write_o),
        .entry_free_o  (entry_free),
        .free_o        (free)
    );

endmodule : store_buffer_top

`default_nettype wire

// ==== sources.f ====
hdl/stb_pkg.sv
hdl/stb_entry.sv
hdl/stb_alloc.sv
hdl/stb_drain.sv
hdl/stb_forward.sv
hdl/store_buffer_top.sv
testbench/tb_store_buffer.sv

// ==== testbench/tb_store_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_store_buffer;

    import stb_pkg::*;

    // Probe address that no test ever stores to
    localparam data_word_t IDLE_ADDR = 32'h00ff_0000;

    // Reference copy of one buffered store
    typedef struct packed {
        logic       committed;
        store_req_t req;
    } model_entry_t;

    logic         clk_i, rst_n_i, push_i, commit_i, flush_i, mem_done_i;
    store_req_t   push_req_i;
    data_word_t   fwd_addr_i, fwd_data_o;
    store_width_t fwd_width_i;
    logic         fwd_hit_o, fwd_wait_o, mem_req_o, full_o, empty_o;
    mem_write_t   mem_write_o;

    model_entry_t model_q[$];
    logic         pend_push, pend_commit, pend_flush;
    store_req_t   pend_req;
    int unsigned  req_count;
    int unsigned  seed_draw;

    store_buffer_top uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push_i),
        .push_req_i  (push_req_i),
        .commit_i    (commit_i),
        .flush_i     (flush_i),
        .fwd_addr_i  (fwd_addr_i),
        .fwd_width_i (fwd_width_i),
        .fwd_hit_o   (fwd_hit_o),
        .fwd_wait_o  (fwd_wait_o),
        .fwd_data_o  (fwd_data_o),
        .mem_req_o   (mem_req_o),
        .mem_write_o (mem_write_o),
        .mem_done_i  (mem_done_i),
        .full_o      (full_o),
        .empty_o     (empty_o)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end : clock_gen

    // ==========================================================================
    // Error reporting and compare tasks
    // ==========================================================================

    task automatic abort(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        abort($sformatf("[FAIL] %0t ns: %s", $time, msg));
    endtask

    task automatic check_mem_write(input mem_write_t exp_w, input mem_write_t act_w);
        if (act_w !== exp_w) begin
            report_mismatch($sformatf("mem_write_o %h/%0d/%h, expected %h/%0d/%h",
                act_w.addr, act_w.width, act_w.data, exp_w.addr, exp_w.width, exp_w.data));
        end
    endtask

    task automatic check_fwd(input logic exp_hit, input logic exp_wait, input data_word_t exp_data);
        if (fwd_hit_o !== exp_hit || fwd_wait_o !== exp_wait) begin
            report_mismatch($sformatf("Forward hit %b wait %b, expected hit %b wait %b",
                fwd_hit_o, fwd_wait_o, exp_hit, exp_wait));
        end else if (exp_hit && fwd_data_o !== exp_data) begin
            report_mismatch($sformatf("Forward data %h, expected %h", fwd_data_o, exp_data));
        end
    endtask

    task automatic check_flags(input logic exp_full, input logic exp_empty);
        if (full_o !== exp_full || empty_o !== exp_empty) begin
            report_mismatch($sformatf("full %b empty %b, expected full %b empty %b",
                full_o, empty_o, exp_full, exp_empty));
        end
    endtask

    // ==========================================================================
    // Reference model
    // ==========================================================================

    // Brings the model up to the strobes the DUT sampled on this edge
    task automatic apply_pending();
        model_entry_t e;
        logic         marked;
        marked = 1'b0;
        if (pend_flush) begin
            // Committed stores always form the front of the queue
            while (model_q.size() > 0 && !model_q[model_q.size()-1].committed) begin
                model_q.delete(model_q.size() - 1);
            end
        end else begin
            for (int i = 0; i < model_q.size(); i++) begin
                if (pend_commit && !marked && !model_q[i].committed) begin
                    model_q[i].committed = 1'b1;
                    marked = 1'b1;
                end
            end
            if (pend_push) begin
                e.committed = 1'b0;
                e.req       = pend_req;
                model_q.push_back(e);
            end
        end
    endtask

    // Youngest store in the same word decides, exact address and width forward
    task automatic expect_fwd(input data_word_t addr, input store_width_t width,
                              output logic hit, output logic stall, output data_word_t data);
        hit   = 1'b0;
        stall = 1'b0;
        data  = '0;
        for (int i = model_q.size() - 1; i >= 0; i--) begin
            if (!hit && !stall && model_q[i].req.addr[31:2] == addr[31:2]) begin
                if (model_q[i].req.addr == addr && model_q[i].req.width == width) begin
                    hit  = 1'b1;
                    data = model_q[i].req.data;
                end else begin
                    stall = 1'b1;
                end
            end
        end
    endtask

    // Stores still waiting for a commit, minus the commit already in flight
    function automatic int open_stores();
        int n;
        n = 0;
        foreach (model_q[i]) begin
            if (!model_q[i].committed) n++;
        end
        return n - int'(pend_commit);
    endfunction

    function automatic store_req_t random_store();
        store_req_t r;
        r.addr  = 32'h0000_1000 + $urandom_range(15, 0);
        r.width = store_width_t'($urandom_range(2, 0));
        r.data  = $urandom();
        return r;
    endfunction

    // Memory controller: checks each write against the oldest committed store
    // Request and write are looked at mid-cycle, done is driven on the edge
    initial begin : mem_responder
        int unsigned delay;
        mem_write_t  exp_w;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && mem_req_o) begin
                if (model_q.size() == 0 || !model_q[0].committed) begin
                    abort("Memory request arrived while the model holds no committed store");
                end
                exp_w.addr  = model_q[0].req.addr;
                exp_w.width = model_q[0].req.width;
                exp_w.data  = model_q[0].req.data;
                check_mem_write(exp_w, mem_write_o);
                req_count++;
                delay = $urandom_range(5, 1);
                repeat (delay - 1) begin
                    @(negedge clk_i);
                    if (mem_req_o) report_mismatch("Second mem_req_o while one is outstanding");
                end
                @(posedge clk_i);
                mem_done_i <= 1'b1;
                @(negedge clk_i);
                if (mem_req_o) report_mismatch("Second mem_req_o while one is outstanding");
                @(posedge clk_i);
                mem_done_i <= 1'b0;
                model_q.delete(0);
            end
        end
    end : mem_responder

    // ==========================================================================
    // Stimulus
    // ==========================================================================

    // One clock cycle of strobes plus a load probe, checked at the falling edge
    task automatic step(input logic push, input store_req_t req, input logic commit,
                        input logic flush, input data_word_t addr, input store_width_t width);
        logic       exp_hit, exp_wait;
        data_word_t exp_data;
        @(posedge clk_i);
        apply_pending();
        push_i      <= push;
        push_req_i  <= req;
        commit_i    <= commit;
        flush_i     <= flush;
        fwd_addr_i  <= addr;
        fwd_width_i <= width;
        pend_push   = push;
        pend_req    = req;
        pend_commit = commit;
        pend_flush  = flush;
        @(negedge clk_i);
        expect_fwd(addr, width, exp_hit, exp_wait, exp_data);
        check_fwd(exp_hit, exp_wait, exp_data);
        check_flags(model_q.size() == STB_DEPTH, model_q.size() == 0);
    endtask

    task automatic idle();
        step(1'b0, '0, 1'b0, 1'b0, IDLE_ADDR, STORE_WORD);
    endtask

    task automatic push_store(input store_req_t req);
        step(1'b1, req, 1'b0, 1'b0, IDLE_ADDR, STORE_WORD);
    endtask

    task automatic commit_one();
        step(1'b0, '0, 1'b1, 1'b0, IDLE_ADDR, STORE_WORD);
    endtask

    task automatic flush_buffer();
        step(1'b0, '0, 1'b0, 1'b1, IDLE_ADDR, STORE_WORD);
    endtask

    task automatic probe(input data_word_t addr, input store_width_t width);
        step(1'b0, '0, 1'b0, 1'b0, addr, width);
    endtask

    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        while (model_q.size() != 0 || pend_push) begin
            if (cycles == limit) begin
                abort($sformatf("Timeout: %0d stores still buffered after %0d cycles",
                    model_q.size(), limit));
            end
            idle();
            cycles++;
        end
    endtask

    task automatic wait_first_free(input int limit);
        int cycles;
        cycles = 0;
        while (model_q.size() == STB_DEPTH) begin
            if (cycles == limit) abort("Timeout: no store left the full buffer");
            idle();
            cycles++;
        end
    endtask

    // ==========================================================================
    // Directed tests
    // ==========================================================================

    task automatic drain_in_order();
        int unsigned start_reqs;
        start_reqs = req_count;
        repeat (STB_DEPTH) push_store(random_store());
        repeat (STB_DEPTH) commit_one();
        wait_drained(60);
        check_flags(1'b0, 1'b1);
        if (req_count - start_reqs != STB_DEPTH) begin
            report_mismatch($sformatf("%0d memory requests for 4 stores", req_count - start_reqs));
        end
    endtask

    task automatic flag_sequence();
        repeat (STB_DEPTH) push_store(random_store());
        idle();
        check_flags(1'b1, 1'b0);
        repeat (STB_DEPTH) commit_one();
        wait_first_free(40);
        check_flags(1'b0, 1'b0);
        wait_drained(60);
        check_flags(1'b0, 1'b1);
    endtask

    task automatic forward_youngest();
        store_req_t older, younger;
        older.addr    = 32'h0000_2040;
        older.width   = STORE_WORD;
        older.data    = 32'h1111_aaaa;
        younger       = older;
        younger.data  = 32'h2222_bbbb;
        push_store(older);
        push_store(younger);
        probe(older.addr, STORE_WORD);
        check_fwd(1'b1, 1'b0, younger.data);
        probe(32'h0000_2080, STORE_WORD);
        check_fwd(1'b0, 1'b0, '0);
        commit_one();
        commit_one();
        wait_drained(60);
    endtask

    task automatic partial_overlap();
        store_req_t byte_st;
        byte_st.addr  = 32'h0000_2101;
        byte_st.width = STORE_BYTE;
        byte_st.data  = 32'h0000_00cd;
        push_store(byte_st);
        probe(32'h0000_2100, STORE_WORD);
        check_fwd(1'b0, 1'b1, '0);
        commit_one();
        wait_drained(60);
    endtask

    task automatic flush_speculative();
        store_req_t  st;
        int unsigned start_reqs;
        start_reqs = req_count;
        st.width   = STORE_WORD;
        for (int i = 0; i < 3; i++) begin
            st.addr = 32'h0000_3000 + 4 * i;
            st.data = 32'h5a5a_0000 + i;
            push_store(st);
        end
        commit_one();
        flush_buffer();
        probe(32'h0000_3004, STORE_WORD);
        check_fwd(1'b0, 1'b0, '0);
        wait_drained(60);
        if (req_count - start_reqs != 1) begin
            report_mismatch($sformatf("%0d memory requests after flush, expected 1",
                req_count - start_reqs));
        end
    endtask

    task automatic random_mix(input int cycles);
        logic do_push, do_commit, do_flush;
        for (int n = 0; n < cycles; n++) begin
            // Occupancy counts the push in flight, so a late free only adds margin
            do_push   = ($urandom_range(1, 0) == 1) &&
                        (model_q.size() + int'(pend_push) < STB_DEPTH);
            do_commit = ($urandom_range(2, 0) == 0) && !pend_flush && (open_stores() > 0);
            do_flush  = !do_push && !do_commit && ($urandom_range(39, 0) == 0);
            step(do_push, random_store(), do_commit, do_flush,
                 32'h0000_1000 + $urandom_range(15, 0), store_width_t'($urandom_range(2, 0)));
        end
        idle();
        for (int n = 0; n <= STB_DEPTH && open_stores() > 0; n++) commit_one();
        wait_drained(100);
    endtask

    initial begin : main_seq
        seed_draw   = $urandom(32'h54f4_17c5);
        req_count   = 0;
        pend_push   = 1'b0;
        pend_commit = 1'b0;
        pend_flush  = 1'b0;
        pend_req    = '0;
        rst_n_i     = 1'b0;
        push_i      = 1'b0;
        push_req_i  = '0;
        commit_i    = 1'b0;
        flush_i     = 1'b0;
        fwd_addr_i  = IDLE_ADDR;
        fwd_width_i = STORE_WORD;
        mem_done_i  = 1'b0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_flags(1'b0, 1'b1);
        check_fwd(1'b0, 1'b0, '0);
        if (mem_req_o !== 1'b0) report_mismatch("mem_req_o high after reset");
        drain_in_order();
        flag_sequence();
        forward_youngest();
        partial_overlap();
        flush_speculative();
        random_mix(200);
        if (model_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort("Stores left in the model at the end of the run");
        end
    end : main_seq

endmodule : tb_store_buffer

`default_nettype wire
